/* logic/xbar_config.svh */
//==========================================================================
// banked scratchpad crossbar sizes
// port count, bank geometry and the widths derived from them
//==========================================================================
`ifndef XBAR_CONFIG_SVH
`define XBAR_CONFIG_SVH

// request ports into the crossbar
`define XBAR_NUM_PORTS 4

// number of banks, power of two
`define XBAR_NUM_BANKS 4

// words held by each bank, power of two
`define XBAR_BANK_WORDS 16

// data word width in bits
`define XBAR_DATA_WIDTH 32

// derived widths, bank number sits in the top address bits
`define XBAR_BANK_BITS ($clog2(`XBAR_NUM_BANKS))
`define XBAR_OFFSET_BITS ($clog2(`XBAR_BANK_WORDS))
`define XBAR_ADDR_BITS (`XBAR_BANK_BITS + `XBAR_OFFSET_BITS)
`define XBAR_MASK_BITS (`XBAR_DATA_WIDTH / 8)

`endif

/* logic/xbar_pkg.sv */
//==========================================================================
// banked crossbar types
// request, bank access and response words shared across the pipeline
//==========================================================================
`include "xbar_config.svh"

package xbar_pkg;

  // one port's request, address split into bank and word offset
  typedef struct packed {
    logic                           write;
    logic [`XBAR_BANK_BITS-1:0]     bank;
    logic [`XBAR_OFFSET_BITS-1:0]   offset;
    logic [`XBAR_DATA_WIDTH-1:0]    data;
    // 1 = write this byte
    logic [`XBAR_MASK_BITS-1:0]     mask;
  } xbar_port_req_t;

  // granted access presented to one bank
  typedef struct packed {
    logic                           valid;
    logic                           write;
    logic [`XBAR_OFFSET_BITS-1:0]   offset;
    logic [`XBAR_DATA_WIDTH-1:0]    data;
    logic [`XBAR_MASK_BITS-1:0]     mask;
    // one-hot, names the granted port
    logic [`XBAR_NUM_PORTS-1:0]     port;
  } xbar_bank_req_t;

  // read data returned to one port
  typedef struct packed {
    logic                           valid;
    logic [`XBAR_DATA_WIDTH-1:0]    data;
  } xbar_port_rsp_t;

endpackage

/* logic/xbar_bank_arbiter.sv */
//==========================================================================
// round-robin arbiter for one bank
// grants one requesting port per cycle, priority rotates past the winner
//==========================================================================
`include "xbar_config.svh"

module xbar_bank_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [`XBAR_NUM_PORTS-1:0]  reqs_i,
  output logic [`XBAR_NUM_PORTS-1:0]  grants_o
);

  localparam int PTR_W = $clog2(`XBAR_NUM_PORTS);

  // port with highest priority this cycle
  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] ptr_d;

  // scan in cyclic order starting at the pointer
  always_comb
  begin
    int  idx;
    logic found;
    grants_o = '0;
    ptr_d    = ptr_q;
    found    = 1'b0;
    for (int i = 0; i < `XBAR_NUM_PORTS; i++)
    begin
      idx = (int'(ptr_q) + i) % `XBAR_NUM_PORTS;
      if (!found && reqs_i[idx])
      begin
        found         = 1'b1;
        grants_o[idx] = 1'b1;
        // winner drops to lowest priority
        ptr_d         = PTR_W'((idx + 1) % `XBAR_NUM_PORTS);
      end
    end
  end

  // pointer holds when nothing is granted
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      ptr_q <= '0;
    end
    else
    begin
      ptr_q <= ptr_d;
    end
  end

endmodule

/* logic/xbar_request_stage.sv */
//==========================================================================
// crossbar request stage
// bank decode, per-bank arbitration and routing of granted requests
//==========================================================================
`include "xbar_config.svh"

module xbar_request_stage
  import xbar_pkg::*;
(
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic           [`XBAR_NUM_PORTS-1:0]     req_v_i,
  input  xbar_port_req_t [`XBAR_NUM_PORTS-1:0]     req_i,
  output logic           [`XBAR_NUM_PORTS-1:0]     yumi_o,
  output xbar_bank_req_t [`XBAR_NUM_BANKS-1:0]     bank_req_o
);

  // bank wanted by each port, one-hot, zero when idle
  logic [`XBAR_NUM_PORTS-1:0][`XBAR_NUM_BANKS-1:0] port_bank_sel;
  // same bits seen from the bank side
  logic [`XBAR_NUM_BANKS-1:0][`XBAR_NUM_PORTS-1:0] bank_port_sel;
  logic [`XBAR_NUM_BANKS-1:0][`XBAR_NUM_PORTS-1:0] bank_grants;

  for (genvar p = 0; p < `XBAR_NUM_PORTS; p++)
  begin : g_decode
    for (genvar b = 0; b < `XBAR_NUM_BANKS; b++)
    begin : g_bank
      assign port_bank_sel[p][b] = req_v_i[p] && (req_i[p].bank == `XBAR_BANK_BITS'(b));
      // transpose
      assign bank_port_sel[b][p] = port_bank_sel[p][b];
    end
  end

  for (genvar b = 0; b < `XBAR_NUM_BANKS; b++)
  begin : g_arb
    xbar_bank_arbiter i_arb (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .reqs_i   (bank_port_sel[b]),
      .grants_o (bank_grants[b])
    );
  end

  // mux the winning port's fields onto each bank
  always_comb
  begin
    bank_req_o = '0;
    for (int b = 0; b < `XBAR_NUM_BANKS; b++)
    begin
      bank_req_o[b].valid = |bank_grants[b];
      bank_req_o[b].port  = bank_grants[b];
      for (int p = 0; p < `XBAR_NUM_PORTS; p++)
      begin
        if (bank_grants[b][p])
        begin
          bank_req_o[b].write  = req_i[p].write;
          bank_req_o[b].offset = req_i[p].offset;
          bank_req_o[b].data   = req_i[p].data;
          bank_req_o[b].mask   = req_i[p].mask;
        end
      end
    end
  end

  // a port is accepted when any bank picked it
  always_comb
  begin
    yumi_o = '0;
    for (int p = 0; p < `XBAR_NUM_PORTS; p++)
    begin
      for (int b = 0; b < `XBAR_NUM_BANKS; b++)
      begin
        yumi_o[p] = yumi_o[p] | bank_grants[b][p];
      end
    end
  end

endmodule

/* logic/xbar_bank_mem.sv */
//==========================================================================
// single-port bank storage
// byte-masked writes, registered read data
//==========================================================================
`include "xbar_config.svh"

module xbar_bank_mem
  import xbar_pkg::*;
(
  input  logic                          clk_i,
  input  xbar_bank_req_t                bank_req_i,
  output logic [`XBAR_DATA_WIDTH-1:0]   rd_data_o
);

  logic [`XBAR_DATA_WIDTH-1:0] mem_q [`XBAR_BANK_WORDS];

  // write only the bytes flagged in the mask
  always_ff @(posedge clk_i)
  begin
    if (bank_req_i.valid && bank_req_i.write)
    begin
      for (int i = 0; i < `XBAR_MASK_BITS; i++)
      begin
        if (bank_req_i.mask[i])
        begin
          mem_q[bank_req_i.offset][i*8 +: 8] <= bank_req_i.data[i*8 +: 8];
        end
      end
    end
  end

  // read word appears the cycle after acceptance
  // output holds its last value on writes and idle cycles
  always_ff @(posedge clk_i)
  begin
    if (bank_req_i.valid && !bank_req_i.write)
    begin
      rd_data_o <= mem_q[bank_req_i.offset];
    end
  end

endmodule

/* logic/xbar_response_stage.sv */
//==========================================================================
// crossbar response stage
// remembers who each bank served, returns read data to that port
//==========================================================================
`include "xbar_config.svh"

module xbar_response_stage
  import xbar_pkg::*;
(
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  xbar_bank_req_t [`XBAR_NUM_BANKS-1:0]        bank_req_i,
  input  logic [`XBAR_NUM_BANKS-1:0][`XBAR_DATA_WIDTH-1:0] bank_rd_data_i,
  output xbar_port_rsp_t [`XBAR_NUM_PORTS-1:0]        rsp_o
);

  // granted port and read flag per bank, one cycle behind
  logic [`XBAR_NUM_BANKS-1:0][`XBAR_NUM_PORTS-1:0] port_q;
  logic [`XBAR_NUM_BANKS-1:0]                      rd_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      port_q <= '0;
      rd_q   <= '0;
    end
    else
    begin
      for (int b = 0; b < `XBAR_NUM_BANKS; b++)
      begin
        port_q[b] <= bank_req_i[b].port;
        rd_q[b]   <= bank_req_i[b].valid & ~bank_req_i[b].write;
      end
    end
  end

  // each port gets data from at most one bank per cycle
  always_comb
  begin
    rsp_o = '0;
    for (int b = 0; b < `XBAR_NUM_BANKS; b++)
    begin
      for (int p = 0; p < `XBAR_NUM_PORTS; p++)
      begin
        if (rd_q[b] && port_q[b][p])
        begin
          rsp_o[p].valid = 1'b1;
          rsp_o[p].data  = bank_rd_data_i[b];
        end
      end
    end
  end

endmodule

/* logic/banked_xbar_top.sv */
//==========================================================================
// banked scratchpad crossbar
// arbitrated port requests into single-port banks, reads return next cycle
//==========================================================================
`include "xbar_config.svh"

module banked_xbar_top
  import xbar_pkg::*;
(
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic           [`XBAR_NUM_PORTS-1:0]    req_v_i,
  input  xbar_port_req_t [`XBAR_NUM_PORTS-1:0]    req_i,
  output logic           [`XBAR_NUM_PORTS-1:0]    yumi_o,
  output xbar_port_rsp_t [`XBAR_NUM_PORTS-1:0]    rsp_o
);

  xbar_bank_req_t [`XBAR_NUM_BANKS-1:0]                      bank_req;
  logic           [`XBAR_NUM_BANKS-1:0][`XBAR_DATA_WIDTH-1:0] bank_rd_data;

  xbar_request_stage i_request (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_v_i    (req_v_i),
    .req_i      (req_i),
    .yumi_o     (yumi_o),
    .bank_req_o (bank_req)
  );

  for (genvar b = 0; b < `XBAR_NUM_BANKS; b++)
  begin : g_bank
    xbar_bank_mem i_mem (
      .clk_i      (clk_i),
      .bank_req_i (bank_req[b]),
      .rd_data_o  (bank_rd_data[b])
    );
  end

  xbar_response_stage i_response (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .bank_req_i     (bank_req),
    .bank_rd_data_i (bank_rd_data),
    .rsp_o          (rsp_o)
  );

endmodule

/* bench/xbar_assertions.sv */
//==========================================================================
// crossbar protocol checks, bound into the top level
//==========================================================================
`include "xbar_config.svh"

module xbar_assertions
  import xbar_pkg::*;
(
  input logic                                  clk_i,
  input logic                                  rst_n_i,
  input logic           [`XBAR_NUM_PORTS-1:0]  req_v_i,
  input xbar_port_req_t [`XBAR_NUM_PORTS-1:0]  req_i,
  input logic           [`XBAR_NUM_PORTS-1:0]  yumi_i,
  input xbar_bank_req_t [`XBAR_NUM_BANKS-1:0]  bank_req_i,
  input xbar_port_rsp_t [`XBAR_NUM_PORTS-1:0]  rsp_i
);

  logic [`XBAR_NUM_PORTS-1:0] rsp_valid;

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (yumi_i & ~req_v_i) == '0)
    else $error("yumi_o raised for a port without a valid request");

  for (genvar b = 0; b < `XBAR_NUM_BANKS; b++)
  begin : g_bank
    a_grant_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(bank_req_i[b].port))
      else $error("bank %0d granted more than one port", b);
  end

  for (genvar p = 0; p < `XBAR_NUM_PORTS; p++)
  begin : g_port
    assign rsp_valid[p] = rsp_i[p].valid;
    // response exactly one cycle after an accepted read
    a_read_gets_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      yumi_i[p] && !req_i[p].write |=> rsp_i[p].valid)
      else $error("port %0d read accepted without a response", p);
    a_rsp_from_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_i[p].valid |-> $past(yumi_i[p] && !req_i[p].write))
      else $error("port %0d response without an accepted read", p);
  end

  a_rsp_idle_after_reset: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> rsp_valid == '0)
    else $error("response valid set right after reset");

endmodule

bind banked_xbar_top xbar_assertions i_assertions (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .req_v_i    (req_v_i),
  .req_i      (req_i),
  .yumi_i     (yumi_o),
  .bank_req_i (bank_req),
  .rsp_i      (rsp_o)
);

/* bench/xbar_tb.sv */
//==========================================================================
// crossbar testbench
// directed and random port traffic checked against a reference model
//==========================================================================
`include "xbar_config.svh"

module xbar_tb
  import xbar_pkg::*;
();

  localparam int NP = `XBAR_NUM_PORTS;
  localparam int NB = `XBAR_NUM_BANKS;
  localparam int BW = `XBAR_BANK_WORDS;
  localparam int DW = `XBAR_DATA_WIDTH;
  localparam int MB = `XBAR_MASK_BITS;
  localparam int RESET_CYCLES = 16;
  localparam int RAND_CYCLES = 400;
  // idle, fill and readback, masks, parallel, conflict, random
  localparam int TEST_CYCLES = 8 + 2 * NB * BW + 5 + 1 + 4 * NP + RAND_CYCLES;
  localparam int MAX_CYCLES = TEST_CYCLES * 4 + RESET_CYCLES;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic [NP-1:0]           req_v;
  xbar_port_req_t [NP-1:0] req;
  logic [NP-1:0]           yumi;
  xbar_port_rsp_t [NP-1:0] rsp;

  // reference model state
  logic [DW-1:0]  model_mem [NB][BW];
  int             ptr [NB];
  logic [NP-1:0]  exp_rsp_v;
  logic [DW-1:0]  exp_rsp_d [NP];
  // yumi seen at the last rising edge
  logic [NP-1:0]  acc_q;
  xbar_port_req_t pend_q [NP][$];
  int errors = 0;
  int checks = 0;
  int cycles = 0;

  banked_xbar_top i_dut (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .req_v_i (req_v),
    .req_i   (req),
    .yumi_o  (yumi),
    .rsp_o   (rsp)
  );

  always #50 clk = ~clk;

  // first requester at or after the pointer, scanned backwards
  function automatic logic [NP-1:0] rr_pick(input int start, input logic [NP-1:0] reqs);
    logic [NP-1:0] pick;
    int idx;
    pick = '0;
    for (int i = NP - 1; i >= 0; i--)
    begin
      idx = (start + i) % NP;
      if (reqs[idx])
      begin
        pick = '0;
        pick[idx] = 1'b1;
      end
    end
    return pick;
  endfunction

  function automatic logic [DW-1:0] merge_write(input logic [DW-1:0] old_word,
                                                input logic [DW-1:0] new_word,
                                                input logic [MB-1:0] mask);
    logic [DW-1:0] res;
    res = old_word;
    for (int i = 0; i < MB; i++)
    begin
      if (mask[i])
        res[i*8 +: 8] = new_word[i*8 +: 8];
    end
    return res;
  endfunction

  function automatic xbar_port_req_t make_req(input logic wr, input int addr,
                                              input logic [DW-1:0] data,
                                              input logic [MB-1:0] mask);
    xbar_port_req_t r;
    r.write  = wr;
    r.bank   = `XBAR_BANK_BITS'(addr / BW);
    r.offset = `XBAR_OFFSET_BITS'(addr % BW);
    r.data   = data;
    r.mask   = mask;
    return r;
  endfunction

  // every address bit shows up in the word
  function automatic logic [DW-1:0] fill_word(input int addr);
    return DW'({4{6'(addr), 2'b01}} ^ 32'h5a5a_a5a5);
  endfunction

  always @(posedge clk)
  begin : compare
    logic [NP-1:0] reqs;
    logic [NP-1:0] grant;
    logic [NP-1:0] exp_yumi;
    logic [NP-1:0] next_v;
    logic [DW-1:0] next_d [NP];
    if (!rst_n)
    begin
      exp_rsp_v = '0;
      acc_q = '0;
      for (int b = 0; b < NB; b++)
        ptr[b] = 0;
    end
    else
    begin
      // reads accepted at the previous edge
      for (int p = 0; p < NP; p++)
      begin
        checks++;
        assert (rsp[p].valid === exp_rsp_v[p])
        else
        begin
          $display("error rsp_o[%0d].valid expected %h got %h", p, exp_rsp_v[p], rsp[p].valid);
          errors++;
        end
        if (exp_rsp_v[p])
        begin
          checks++;
          assert (rsp[p].data === exp_rsp_d[p])
          else
          begin
            $display("error rsp_o[%0d].data expected %h got %h", p, exp_rsp_d[p], rsp[p].data);
            errors++;
          end
        end
      end
      exp_yumi = '0;
      next_v = '0;
      for (int b = 0; b < NB; b++)
      begin
        for (int p = 0; p < NP; p++)
          reqs[p] = req_v[p] && (int'(req[p].bank) == b);
        grant = rr_pick(ptr[b], reqs);
        for (int p = 0; p < NP; p++)
        begin
          if (grant[p])
          begin
            exp_yumi[p] = 1'b1;
            ptr[b] = (p + 1) % NP;
            if (req[p].write)
              model_mem[b][req[p].offset] = merge_write(model_mem[b][req[p].offset],
                                                        req[p].data, req[p].mask);
            else
            begin
              next_v[p] = 1'b1;
              next_d[p] = model_mem[b][req[p].offset];
            end
          end
        end
      end
      checks++;
      assert (yumi === exp_yumi)
      else
      begin
        $display("error yumi_o expected %h got %h", exp_yumi, yumi);
        errors++;
      end
      acc_q = yumi;
      exp_rsp_v = next_v;
      exp_rsp_d = next_d;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, requests were never drained", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  // a port moves on only after its request was accepted
  task automatic drive_queues();
    logic busy;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < NP; p++)
      begin
        if (!req_v[p] || acc_q[p])
        begin
          if (pend_q[p].size() > 0)
          begin
            req[p] = pend_q[p].pop_front();
            req_v[p] = 1'b1;
          end
          else
            req_v[p] = 1'b0;
        end
        busy = busy | req_v[p];
      end
    end
    // last response lands one edge later
    repeat (2) @(negedge clk);
  endtask

  initial
  begin
    int base;
    void'($urandom(32'h41b1_81fe));
    rst_n = 1'b0;
    req_v = '0;
    req = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    base = errors;
    repeat (8) @(negedge clk);
    $display("test 1 idle after reset: %0d errors", errors - base);

    base = errors;
    for (int a = 0; a < NB * BW; a++)
      pend_q[0].push_back(make_req(1'b1, a, fill_word(a), '1));
    for (int a = 0; a < NB * BW; a++)
      pend_q[0].push_back(make_req(1'b0, a, '0, '0));
    drive_queues();
    $display("test 2 fill and readback: %0d errors", errors - base);

    // read then write back to back returns the old word
    base = errors;
    pend_q[1].push_back(make_req(1'b1, 37, 32'hc0de_0011, 4'b0001));
    pend_q[1].push_back(make_req(1'b0, 37, '0, '0));
    pend_q[1].push_back(make_req(1'b1, 37, 32'h7e57_2200, 4'b0110));
    pend_q[1].push_back(make_req(1'b1, 37, 32'hbeef_0000, 4'b0000));
    pend_q[1].push_back(make_req(1'b0, 37, '0, '0));
    drive_queues();
    $display("test 3 byte masks: %0d errors", errors - base);

    base = errors;
    for (int p = 0; p < NP; p++)
      pend_q[p].push_back(make_req(1'b0, p * BW + 5 + p, '0, '0));
    drive_queues();
    $display("test 4 parallel banks: %0d errors", errors - base);

    // bank 3 last served port 3, so rotation starts at port 0
    base = errors;
    for (int k = 0; k < 4; k++)
    begin
      for (int p = 0; p < NP; p++)
        pend_q[p].push_back(make_req(1'b0, 3 * BW + 4 * k + p, '0, '0));
    end
    drive_queues();
    $display("test 5 bank conflict rotation: %0d errors", errors - base);

    base = errors;
    repeat (RAND_CYCLES)
    begin
      @(negedge clk);
      for (int p = 0; p < NP; p++)
      begin
        if (!req_v[p] || acc_q[p])
        begin
          req_v[p] = ($urandom % 4) != 0;
          req[p] = make_req($urandom % 2 == 1, int'($urandom % (NB * BW)), $urandom,
                            MB'($urandom));
        end
      end
    end
    drive_queues();
    $display("test 6 random traffic: %0d errors", errors - base);

    $display("6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* project.f */
+incdir+logic
logic/xbar_pkg.sv
logic/xbar_bank_arbiter.sv
logic/xbar_request_stage.sv
logic/xbar_bank_mem.sv
logic/xbar_response_stage.sv
logic/banked_xbar_top.sv
bench/xbar_assertions.sv
bench/xbar_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= xbar_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
